// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic types and request encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        REQ_LOAD  = 2'b00,
        REQ_STORE = 2'b01,
        REQ_MAINT = 2'b10
    } req_kind_e;

    typedef enum logic [1:0] {
        MAINT_NONE        = 2'b00,
        MAINT_INDEX_INVAL = 2'b01,
        MAINT_HIT_INVAL   = 2'b10
    } maint_op_e;

    // CACHE op field: target in the low two bits, operation above it.
    typedef struct packed {
        logic [26:0] pad;
        logic [2:0]  op;
        logic [1:0]  target;
    } cache_cmd_s;

    typedef union packed {
        word_t      data;
        cache_cmd_s cmd;
    } req_payload_u;

    typedef struct packed {
        req_kind_e    kind;
        mem_size_e    size;
        logic         sign;
        word_t        addr;
        req_payload_u payload;
    } cache_req_s;

    // Request as held by the decoder, with lanes and maintenance op resolved.
    typedef struct packed {
        req_kind_e kind;
        mem_size_e size;
        logic      sign;
        word_t     addr;
        logic [3:0] be;
        word_t     wdata;
        maint_op_e maint;
    } lookup_s;

    typedef struct packed {
        logic       write;
        word_t      addr;
        word_t      wdata;
        logic [3:0] strb;
    } mem_req_s;

    localparam logic [1:0] TARGET_DCACHE  = 2'b01;
    localparam logic [2:0] OP_INDEX_INVAL = 3'b000;
    localparam logic [2:0] OP_HIT_INVAL   = 3'b100;

endpackage

`default_nettype wire

// ==== hdl/dcache_req_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_req_decode #(
    parameter int SETS = 8
) (
    input  wire logic                   Clk,
    input  wire logic                   reset,
    input  wire logic                   i_req_valid,
    input  wire dcache_pkg::cache_req_s i_req,
    output logic                        o_req_ready,
    input  wire logic                   i_req_done,
    output logic                        o_lookup_valid,
    output dcache_pkg::lookup_s         o_lookup
);
    import dcache_pkg::*;

    logic    held_q;
    lookup_s decoded;

    // Index extraction in the ways needs a power-of-two set count.
    if (SETS < 2 || (SETS & (SETS - 1)) != 0) begin : g_bad_sets
        $error("dcache_req_decode: SETS must be a power of two and at least 2");
    end

    assign o_req_ready    = !held_q;
    assign o_lookup_valid = held_q;

    ////////////////////////////////////////////////////////////////////////////
    // Lane and maintenance decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        decoded.kind  = i_req.kind;
        decoded.size  = i_req.size;
        decoded.sign  = i_req.sign;
        decoded.addr  = i_req.addr;
        decoded.maint = MAINT_NONE;

        case (i_req.size)
            SIZE_BYTE: begin
                decoded.be    = 4'b0001 << i_req.addr[1:0];
                decoded.wdata = {24'b0, i_req.payload.data[7:0]} << {i_req.addr[1:0], 3'b000};
            end
            SIZE_HALF: begin
                decoded.be    = i_req.addr[1] ? 4'b1100 : 4'b0011;
                decoded.wdata = {16'b0, i_req.payload.data[15:0]} << {i_req.addr[1], 4'b0000};
            end
            default: begin
                decoded.be    = 4'b1111;
                decoded.wdata = i_req.payload.data;
            end
        endcase

        // Only the data cache target with the two kept operations has an effect.
        if (i_req.kind == REQ_MAINT && i_req.payload.cmd.target == TARGET_DCACHE) begin
            case (i_req.payload.cmd.op)
                OP_INDEX_INVAL: decoded.maint = MAINT_INDEX_INVAL;
                OP_HIT_INVAL:   decoded.maint = MAINT_HIT_INVAL;
                default:        decoded.maint = MAINT_NONE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            held_q <= 1'b0;
        end else if (i_req_valid && o_req_ready) begin
            held_q <= 1'b1;
        end else if (i_req_done) begin
            held_q <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_req_valid && o_req_ready) begin
            o_lookup <= decoded;
        end
    end

    // A response can only complete a request that is held.
    a_done_while_held: assert property (
        @(posedge Clk) disable iff (reset)
        i_req_done |-> o_lookup_valid
    );

endmodule

`default_nettype wire

// ==== hdl/dcache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_way #(
    parameter int SETS = 8
) (
    input  wire logic                Clk,
    input  wire logic                reset,
    input  wire logic                i_lookup_valid,
    input  wire dcache_pkg::lookup_s i_lookup,
    input  wire logic                i_fill_en,
    input  wire dcache_pkg::word_t   i_fill_data,
    input  wire logic                i_store_en,
    input  wire logic                i_inval_en,
    output logic                     o_hit,
    output dcache_pkg::word_t        o_rd_data
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 30 - IDX_W;

    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_mem [SETS];
    word_t            data_mem [SETS];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;

    assign idx = i_lookup.addr[IDX_W+1:2];
    assign tag = i_lookup.addr[31:IDX_W+2];

    assign o_hit     = i_lookup_valid && valid_q[idx] && (tag_mem[idx] == tag);
    assign o_rd_data = data_mem[idx];

    always_ff @(posedge Clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (i_fill_en) begin
            valid_q[idx] <= 1'b1;
        end else if (i_inval_en) begin
            valid_q[idx] <= 1'b0;
        end
    end

    // Tag and data arrays. A store only reaches a way that already hit.
    always_ff @(posedge Clk) begin
        if (i_fill_en) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= i_fill_data;
        end else if (i_store_en) begin
            for (int b = 0; b < 4; b++) begin
                if (i_lookup.be[b]) begin
                    data_mem[idx][8*b +: 8] <= i_lookup.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_resp_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_resp_ctrl #(
    parameter int WAYS = 2,
    parameter int SETS = 8
) (
    input  wire logic                         Clk,
    input  wire logic                         reset,
    input  wire logic                         i_lookup_valid,
    input  wire dcache_pkg::lookup_s          i_lookup,
    input  wire logic [WAYS-1:0]              i_hit,
    input  wire dcache_pkg::word_t [WAYS-1:0] i_rd_data,
    output logic [WAYS-1:0]                   o_fill_en,
    output dcache_pkg::word_t                 o_fill_data,
    output logic [WAYS-1:0]                   o_store_en,
    output logic [WAYS-1:0]                   o_inval_en,
    output logic                              o_req_done,
    output logic                              o_mem_valid,
    output dcache_pkg::mem_req_s              o_mem,
    input  wire logic                         i_mem_ready,
    input  wire logic                         i_mem_rvalid,
    input  wire dcache_pkg::word_t            i_mem_rdata,
    output logic                              o_resp_valid,
    output dcache_pkg::word_t                 o_resp_data,
    input  wire logic                         i_resp_ready
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef enum logic [1:0] {ST_IDLE, ST_MEM_WAIT, ST_RESPOND} state_e;

    state_e           state_q;
    word_t            resp_data_q;
    logic [WAYS-1:0]  vmask_q [SETS];
    logic [WAY_W-1:0] rr_q [SETS];

    logic [IDX_W-1:0] idx;
    logic [WAY_W-1:0] inval_way;
    logic [WAY_W-1:0] victim;
    logic             victim_free;
    logic             hit_any;
    logic             fill_go;
    word_t            hit_data;

    function automatic word_t extract(word_t w, mem_size_e size, logic sign, logic [1:0] off);
        word_t       sh_b;
        word_t       sh_h;
        logic [7:0]  b;
        logic [15:0] h;
        sh_b = w >> {off, 3'b000};
        sh_h = w >> {off[1], 4'b0000};
        b    = sh_b[7:0];
        h    = sh_h[15:0];
        case (size)
            SIZE_BYTE: return {{24{sign & b[7]}}, b};
            SIZE_HALF: return {{16{sign & h[15]}}, h};
            default:   return w;
        endcase
    endfunction

    assign idx         = i_lookup.addr[IDX_W+1:2];
    assign inval_way   = i_lookup.addr[IDX_W+2 +: WAY_W];
    assign hit_any     = |i_hit;
    assign fill_go     = (state_q == ST_MEM_WAIT) && i_mem_rvalid;
    assign o_fill_data = i_mem_rdata;

    assign o_resp_valid = (state_q == ST_RESPOND);
    assign o_resp_data  = resp_data_q;
    assign o_req_done   = o_resp_valid && i_resp_ready;

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_hit[w]) begin
                hit_data = i_rd_data[w];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Replacement: lowest empty way, else the set's round-robin pointer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        victim      = rr_q[idx];
        victim_free = 1'b0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!vmask_q[idx][w]) begin
                victim      = WAY_W'(w);
                victim_free = 1'b1;
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            o_fill_en[w] = fill_go && (victim == WAY_W'(w));
        end
    end

    // Mirrors the way valid bits so the victim can be picked without a lookup.
    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                vmask_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill_go) begin
            vmask_q[idx] <= vmask_q[idx] | o_fill_en;
            if (!victim_free) begin
                rr_q[idx] <= (rr_q[idx] == WAY_W'(WAYS - 1)) ? '0 : rr_q[idx] + WAY_W'(1);
            end
        end else if (|o_inval_en) begin
            vmask_q[idx] <= vmask_q[idx] & ~o_inval_en;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request handling
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        o_mem_valid = 1'b0;
        o_store_en  = '0;
        o_inval_en  = '0;
        o_mem.write = (i_lookup.kind == REQ_STORE);
        o_mem.addr  = {i_lookup.addr[31:2], 2'b00};
        o_mem.wdata = i_lookup.wdata;
        o_mem.strb  = (i_lookup.kind == REQ_STORE) ? i_lookup.be : 4'b0000;

        if (state_q == ST_IDLE && i_lookup_valid) begin
            case (i_lookup.kind)
                REQ_LOAD: o_mem_valid = !hit_any;
                REQ_STORE: begin
                    // Write-through; a store miss leaves the cache alone.
                    o_mem_valid = 1'b1;
                    if (i_mem_ready) begin
                        o_store_en = i_hit;
                    end
                end
                default: begin
                    for (int w = 0; w < WAYS; w++) begin
                        o_inval_en[w] = (i_lookup.maint == MAINT_INDEX_INVAL) &&
                                        (inval_way == WAY_W'(w));
                    end
                    if (i_lookup.maint == MAINT_HIT_INVAL) begin
                        o_inval_en = i_hit;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_lookup_valid) begin
                        if (i_lookup.kind == REQ_LOAD && !hit_any) begin
                            if (i_mem_ready) state_q <= ST_MEM_WAIT;
                        end else if (i_lookup.kind == REQ_STORE) begin
                            if (i_mem_ready) state_q <= ST_RESPOND;
                        end else begin
                            state_q <= ST_RESPOND;
                        end
                    end
                end
                ST_MEM_WAIT: if (i_mem_rvalid) state_q <= ST_RESPOND;
                default:     if (i_resp_ready) state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state_q == ST_IDLE) begin
            resp_data_q <= (i_lookup.kind == REQ_LOAD) ?
                extract(hit_data, i_lookup.size, i_lookup.sign, i_lookup.addr[1:0]) : '0;
        end else if (fill_go) begin
            resp_data_q <= extract(i_mem_rdata, i_lookup.size, i_lookup.sign, i_lookup.addr[1:0]);
        end
    end

    // At most one way may claim a tag.
    a_hit_onehot: assert property (
        @(posedge Clk) disable iff (reset) i_lookup_valid |-> $onehot0(i_hit)
    );

    a_mem_stable: assert property (
        @(posedge Clk) disable iff (reset)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem)
    );

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int WAYS = 2,
    parameter int SETS = 8
) (
    input  wire logic                  Clk,
    input  wire logic                  reset,
    input  wire logic                  i_req_valid,
    input  wire dcache_pkg::cache_req_s i_req,
    output logic                       o_req_ready,
    output logic                       o_resp_valid,
    output dcache_pkg::word_t          o_resp_data,
    input  wire logic                  i_resp_ready,
    output logic                       o_mem_valid,
    output dcache_pkg::mem_req_s       o_mem,
    input  wire logic                  i_mem_ready,
    input  wire logic                  i_mem_rvalid,
    input  wire dcache_pkg::word_t     i_mem_rdata
);
    import dcache_pkg::*;

    lookup_s                lookup;
    logic                   lookup_valid;
    logic                   req_done;
    logic [WAYS-1:0]        hit;
    word_t [WAYS-1:0]       rd_data;
    logic [WAYS-1:0]        fill_en;
    logic [WAYS-1:0]        store_en;
    logic [WAYS-1:0]        inval_en;
    word_t                  fill_data;

    dcache_req_decode #(.SETS(SETS)) u_decode (
        .Clk            (Clk),
        .reset          (reset),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_req_ready    (o_req_ready),
        .i_req_done     (req_done),
        .o_lookup_valid (lookup_valid),
        .o_lookup       (lookup)
    );

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        dcache_way #(.SETS(SETS)) u_way (
            .Clk            (Clk),
            .reset          (reset),
            .i_lookup_valid (lookup_valid),
            .i_lookup       (lookup),
            .i_fill_en      (fill_en[g]),
            .i_fill_data    (fill_data),
            .i_store_en     (store_en[g]),
            .i_inval_en     (inval_en[g]),
            .o_hit          (hit[g]),
            .o_rd_data      (rd_data[g])
        );
    end

    dcache_resp_ctrl #(.WAYS(WAYS), .SETS(SETS)) u_resp_ctrl (
        .Clk            (Clk),
        .reset          (reset),
        .i_lookup_valid (lookup_valid),
        .i_lookup       (lookup),
        .i_hit          (hit),
        .i_rd_data      (rd_data),
        .o_fill_en      (fill_en),
        .o_fill_data    (fill_data),
        .o_store_en     (store_en),
        .o_inval_en     (inval_en),
        .o_req_done     (req_done),
        .o_mem_valid    (o_mem_valid),
        .o_mem          (o_mem),
        .i_mem_ready    (i_mem_ready),
        .i_mem_rvalid   (i_mem_rvalid),
        .i_mem_rdata    (i_mem_rdata),
        .o_resp_valid   (o_resp_valid),
        .o_resp_data    (o_resp_data),
        .i_resp_ready   (i_resp_ready)
    );

endmodule

`default_nettype wire

// ==== bench/dcache_tb_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// Helpers for stimulus and expected values
////////////////////////////////////////////////////////////////////////////

function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic word_t model_read(word_t addr);
    word_t a;
    a = {addr[31:2], 2'b00};
    if (mem_model.exists(a)) begin
        return mem_model[a];
    end
    return a ^ 32'h5A5A_0000;
endfunction

function automatic void model_merge(word_t addr, word_t data, logic [3:0] strb);
    word_t w;
    w = model_read(addr);
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            w[8*b +: 8] = data[8*b +: 8];
        end
    end
    mem_model[{addr[31:2], 2'b00}] = w;
endfunction

// Byte or half lane of a word, extended by the sign flag.
function automatic word_t lane_value(word_t w, mem_size_e size, logic sign, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];
    h = w[16*off[1] +: 16];
    if (size == SIZE_BYTE) begin
        return (sign && b[7]) ? {24'hFF_FFFF, b} : {24'h0, b};
    end else if (size == SIZE_HALF) begin
        return (sign && h[15]) ? {16'hFFFF, h} : {16'h0, h};
    end
    return w;
endfunction

function automatic mem_req_s store_request(word_t addr, mem_size_e size, word_t data);
    mem_req_s m;
    int       first;
    int       nbytes;
    first  = 0;
    nbytes = 4;
    if (size == SIZE_BYTE) begin
        first  = int'(addr[1:0]);
        nbytes = 1;
    end else if (size == SIZE_HALF) begin
        first  = 2 * int'(addr[1]);
        nbytes = 2;
    end
    m.write = 1'b1;
    m.addr  = {addr[31:2], 2'b00};
    m.wdata = '0;
    m.strb  = '0;
    for (int b = first; b < first + nbytes; b++) begin
        m.strb[b]         = 1'b1;
        m.wdata[8*b +: 8] = data[8*(b - first) +: 8];
    end
    return m;
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_word(input string test, input word_t exp, input word_t act);
    if (exp !== act) begin
        $display("ERR %s: expected %08h, actual %08h", test, exp, act);
        value_errors++;
    end
endtask

task automatic check_mem(input string test, input mem_req_s exp, input mem_req_s act);
    if (exp !== act) begin
        $write("ERR %s: expected mem w=%0b a=%08h d=%08h s=%04b, ",
               test, exp.write, exp.addr, exp.wdata, exp.strb);
        $display("actual w=%0b a=%08h d=%08h s=%04b",
                 act.write, act.addr, act.wdata, act.strb);
        value_errors++;
    end
endtask

task automatic check_count(input string test, input int exp, input int act);
    if (exp != act) begin
        $display("ERR %s: expected %0d memory accesses, actual %0d", test, exp, act);
        value_errors++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Drive tasks
////////////////////////////////////////////////////////////////////////////

task automatic run_req(input string test, input cache_req_s r, output word_t data);
    int n;
    data = '0;
    @(negedge Clk);
    i_req_valid = 1'b1;
    i_req       = r;
    n = 0;
    do begin
        @(posedge Clk);
        n++;
    end while (!o_req_ready && n < WAIT_LIMIT);
    @(negedge Clk);
    i_req_valid = 1'b0;
    if (n >= WAIT_LIMIT) begin
        $display("%s: request was never accepted", test);
        protocol_errors++;
        return;
    end
    n = 0;
    do begin
        @(posedge Clk);
        n++;
    end while (!(o_resp_valid && i_resp_ready) && n < WAIT_LIMIT);
    if (n >= WAIT_LIMIT) begin
        $display("%s: response never arrived", test);
        protocol_errors++;
        return;
    end
    data = o_resp_data;
endtask

task automatic load_check(input string test, input word_t addr, input mem_size_e size,
                          input logic sign, input int exp_reads);
    word_t    data;
    word_t    exp;
    int       reads0;
    mem_req_s exp_rd;
    reads0 = reads_seen;
    exp    = lane_value(model_read(addr), size, sign, addr[1:0]);
    run_req(test, '{kind: REQ_LOAD, size: size, sign: sign, addr: addr, payload: '0}, data);
    check_word(test, exp, data);
    if (exp_reads >= 0) begin
        check_count(test, exp_reads, reads_seen - reads0);
    end
    if (exp_reads == 1 && reads_seen - reads0 == 1) begin
        exp_rd = '{write: 1'b0, addr: {addr[31:2], 2'b00}, wdata: '0, strb: 4'b0000};
        check_mem(test, exp_rd, last_read);
    end
endtask

task automatic store_check(input string test, input word_t addr, input mem_size_e size,
                           input word_t wdata);
    word_t data;
    int    writes0;
    int    reads0;
    writes0 = writes_seen;
    reads0  = reads_seen;
    run_req(test, '{kind: REQ_STORE, size: size, sign: 1'b0, addr: addr, payload: wdata}, data);
    check_word(test, 32'h0, data);
    check_count(test, 1, writes_seen - writes0);
    check_count(test, 0, reads_seen - reads0);
    check_mem(test, store_request(addr, size, wdata), last_write);
endtask

task automatic maint_check(input string test, input word_t addr, input logic [1:0] target,
                           input logic [2:0] op);
    cache_req_s r;
    word_t      data;
    r.kind         = REQ_MAINT;
    r.size         = SIZE_WORD;
    r.sign         = 1'b0;
    r.addr         = addr;
    r.payload.data = '0;
    r.payload.cmd.op     = op;
    r.payload.cmd.target = target;
    run_req(test, r, data);
    check_word(test, 32'h0, data);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_miss_then_hit();
    load_check("miss_then_hit", 32'h0000_0104, SIZE_WORD, 1'b0, 1);
    load_check("miss_then_hit", 32'h0000_0104, SIZE_WORD, 1'b0, 0);
endtask

task automatic test_subword_loads();
    // Store misses do not allocate, so the load after it refills the merged word.
    store_check("subword_setup", 32'h0000_0208, SIZE_WORD, 32'h80F1_7F92);
    load_check("subword_setup", 32'h0000_0208, SIZE_WORD, 1'b0, 1);
    for (int off = 0; off < 4; off++) begin
        load_check("subword_byte_u", 32'h0000_0208 + off, SIZE_BYTE, 1'b0, 0);
        load_check("subword_byte_s", 32'h0000_0208 + off, SIZE_BYTE, 1'b1, 0);
    end
    for (int off = 0; off < 4; off += 2) begin
        load_check("subword_half_u", 32'h0000_0208 + off, SIZE_HALF, 1'b0, 0);
        load_check("subword_half_s", 32'h0000_0208 + off, SIZE_HALF, 1'b1, 0);
    end
endtask

task automatic test_write_through();
    load_check("write_through", 32'h0000_030C, SIZE_WORD, 1'b0, 1);
    store_check("write_through_b", 32'h0000_030D, SIZE_BYTE, 32'h0000_00AB);
    store_check("write_through_h", 32'h0000_030E, SIZE_HALF, 32'h0000_C3D4);
    load_check("write_through", 32'h0000_030C, SIZE_WORD, 1'b0, 0);
    store_check("write_through_w", 32'h0000_030C, SIZE_WORD, 32'h1234_5678);
    load_check("write_through", 32'h0000_030C, SIZE_WORD, 1'b0, 0);
endtask

task automatic test_maintenance();
    load_check("hit_inval", 32'h0000_0410, SIZE_WORD, 1'b0, 1);
    maint_check("hit_inval", 32'h0000_0410, TARGET_DCACHE, OP_HIT_INVAL);
    load_check("hit_inval", 32'h0000_0410, SIZE_WORD, 1'b0, 1);

    // Set 5 gets one line in each way; address bit 5 names way 1.
    load_check("index_inval", 32'h0000_0514, SIZE_WORD, 1'b0, 1);
    load_check("index_inval", 32'h0000_0534, SIZE_WORD, 1'b0, 1);
    maint_check("index_inval", 32'h0000_0034, TARGET_DCACHE, OP_INDEX_INVAL);
    load_check("index_inval_keep", 32'h0000_0514, SIZE_WORD, 1'b0, 0);
    load_check("index_inval_drop", 32'h0000_0534, SIZE_WORD, 1'b0, 1);

    load_check("maint_ignored", 32'h0000_0618, SIZE_WORD, 1'b0, 1);
    maint_check("maint_ignored", 32'h0000_0618, 2'b00, OP_HIT_INVAL);
    maint_check("maint_ignored", 32'h0000_0618, TARGET_DCACHE, 3'b010);
    load_check("maint_ignored", 32'h0000_0618, SIZE_WORD, 1'b0, 0);
endtask

task automatic test_replacement();
    load_check("replace_a", 32'h0000_001C, SIZE_WORD, 1'b0, 1);
    load_check("replace_b", 32'h0000_003C, SIZE_WORD, 1'b0, 1);
    load_check("replace_c", 32'h0000_005C, SIZE_WORD, 1'b0, 1);
    load_check("replace_a_again", 32'h0000_001C, SIZE_WORD, 1'b0, 1);
    load_check("replace_c_again", 32'h0000_005C, SIZE_WORD, 1'b0, 0);
endtask

task automatic test_back_pressure();
    word_t     r;
    word_t     addr;
    mem_size_e size;
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
        r = next_rand();
        case (r[1:0])
            2'b00:   size = SIZE_BYTE;
            2'b01:   size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
        addr = 32'h0000_0800 + {26'h0, r[7:4], 2'b00};
        if (size == SIZE_BYTE) begin
            addr[1:0] = r[9:8];
        end else if (size == SIZE_HALF) begin
            addr[1] = r[9];
        end
        if (r[12]) begin
            store_check("back_pressure_st", addr, size, next_rand());
        end else begin
            load_check("back_pressure_ld", addr, size, r[13], -1);
        end
    end
    stall_en = 1'b0;
endtask

// ==== bench/dcache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 100;

    logic       Clk;
    logic       reset;
    logic       i_req_valid;
    cache_req_s i_req;
    logic       o_req_ready;
    logic       o_resp_valid;
    word_t      o_resp_data;
    logic       i_resp_ready;
    logic       o_mem_valid;
    mem_req_s   o_mem;
    logic       i_mem_ready;
    logic       i_mem_rvalid;
    word_t      i_mem_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Memory model state and scoreboard counters
    ////////////////////////////////////////////////////////////////////////////

    word_t    mem_model [word_t];
    word_t    rng_state;
    logic     stall_en;
    int       rd_wait;
    word_t    rd_addr;
    int       reads_seen;
    int       writes_seen;
    mem_req_s last_read;
    mem_req_s last_write;
    int       value_errors;
    int       protocol_errors;

    dcache_top #(.WAYS(2), .SETS(8)) dut0 (
        .Clk          (Clk),
        .reset        (reset),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .i_resp_ready (i_resp_ready),
        .o_mem_valid  (o_mem_valid),
        .o_mem        (o_mem),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rdata  (i_mem_rdata)
    );

    `include "dcache_tb_tasks.svh"

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // Memory side accepts requests on the rising edge.
    always @(posedge Clk) begin
        if (!reset && o_mem_valid && i_mem_ready) begin
            if (o_mem.write) begin
                last_write = o_mem;
                writes_seen++;
                model_merge(o_mem.addr, o_mem.wdata, o_mem.strb);
            end else begin
                last_read = o_mem;
                reads_seen++;
                rd_addr = o_mem.addr;
                rd_wait = stall_en ? 1 + int'(next_rand() % 4) : 1;
            end
        end
    end

    // Read return and ready stalls are driven on the falling edge.
    always @(negedge Clk) begin
        i_mem_rvalid = 1'b0;
        i_mem_rdata  = '0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                i_mem_rvalid = 1'b1;
                i_mem_rdata  = model_read(rd_addr);
            end
        end
        i_mem_ready  = stall_en ? ((next_rand() % 3) != 0) : 1'b1;
        i_resp_ready = stall_en ? ((next_rand() % 4) != 0) : 1'b1;
    end

    // The input must stay closed while a response waits.
    always @(posedge Clk) begin
        if (!reset && o_resp_valid && o_req_ready) begin
            $display("Request accepted while a response is still pending at %0t", $time);
            protocol_errors++;
        end
    end

    initial begin
        #(CLK_PERIOD * 400 * NUM_TESTS);
        $display("Watchdog expired: the test sequence did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        Clk             = 1'b0;
        reset           = 1'b1;
        i_req_valid     = 1'b0;
        i_req           = '0;
        i_resp_ready    = 1'b1;
        i_mem_ready     = 1'b1;
        i_mem_rvalid    = 1'b0;
        i_mem_rdata     = '0;
        rng_state       = 32'd67361;
        stall_en        = 1'b0;
        rd_wait         = 0;
        rd_addr         = '0;
        reads_seen      = 0;
        writes_seen     = 0;
        last_read       = '0;
        last_write      = '0;
        value_errors    = 0;
        protocol_errors = 0;

        repeat (3) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;

        test_miss_then_hit();
        test_subword_loads();
        test_write_through();
        test_maintenance();
        test_replacement();
        test_back_pressure();

        repeat (4) @(negedge Clk);
        $display("Summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
hdl/dcache_pkg.sv
hdl/dcache_req_decode.sv
hdl/dcache_way.sv
hdl/dcache_resp_ctrl.sv
hdl/dcache_top.sv
bench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module dcache_tb \
    -f compile.f -o dcache_sim > sim.log 2>&1 &&
./obj_dir/dcache_sim >> sim.log 2>&1 ||
echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST PASS" sim.log || echo "TEST FAIL" >> sim.log
! grep -q "TEST FAIL" sim.log
